// File: common/sparce_pkg.sv
/*
  shared types and table geometry for the sparce skip-prediction unit
  geometry is fixed here, nothing below is parameterized per instance
  the config data word layout is decoded inside the table, see the
  comment next to sasa_cfg_t for the bit positions
*/
`default_nettype none

package sparce_pkg;

  // table geometry
  localparam int SASA_SETS = 4;
  localparam int SASA_WAYS = 4;

  // config address that selects a table write, any other address is ignored
  localparam logic [31:0] SASA_ADDR = 32'h0000_1000;

  // architectural register count
  localparam int NUM_REGS = 32;

  // plain vectors with a meaning
  typedef logic [31:0] word_t;
  typedef logic [31:0] pc_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  skip_cnt_t;
  typedef logic [1:0]  set_idx_t;
  typedef logic [13:0] tag_t;
  typedef logic [1:0]  way_idx_t;
  // lru age, 0 is most recently used, 3 is the next victim
  typedef logic [1:0]  usage_t;

  // skip condition on the zero state of rs1 and rs2
  typedef enum logic {
    SASA_COND_OR  = 1'b0,
    SASA_COND_AND = 1'b1
  } sasa_cond_t;

  // one stored descriptor
  typedef struct packed {
    usage_t     usage;
    logic       valid;
    tag_t       tag;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    sasa_cond_t cond;
    skip_cnt_t  skip_cnt;
  } sasa_entry_t;

  // one config write
  // data: [31:18] tag, [17:16] set, [15:11] rs1, [10:6] rs2,
  // [5] cond, [4:0] skip count
  typedef struct packed {
    word_t addr;
    word_t data;
  } sasa_cfg_t;

  // writeback from the core
  typedef struct packed {
    reg_idx_t idx;
    word_t    value;
  } wb_t;

  // stage 1 payload, fields are zero on a miss except pc
  typedef struct packed {
    logic       hit;
    pc_t        pc;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    sasa_cond_t cond;
    skip_cnt_t  skip_cnt;
  } lookup_t;

  // stage 2 decision
  typedef struct packed {
    logic skip;
    pc_t  target;
  } sparce_result_t;

endpackage

`default_nettype wire

// File: sparce/sparce_sprf.sv
/*
  sparsity register file, one zero flag per architectural register
  every flag resets to 1 since the core's register file resets to zero
  register 0 always reads zero and its writebacks are dropped
  reads forward a same-cycle writeback to the same index
*/
`default_nettype none

module sparce_sprf (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                wb_valid,
  input  sparce_pkg::wb_t     wb,
  input  sparce_pkg::reg_idx_t rs1,
  input  sparce_pkg::reg_idx_t rs2,
  output logic                zero1,
  output logic                zero2
);

  // flag set means the register currently holds zero
  logic [sparce_pkg::NUM_REGS-1:0] zero_flags;
  logic                            wb_live;
  logic                            wb_zero;

  // writes to register 0 never land
  assign wb_live = wb_valid && (wb.idx != '0);
  assign wb_zero = (wb.value == '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      zero_flags <= '1;
    end else if (wb_live) begin
      zero_flags[wb.idx] <= wb_zero;
    end
  end

  // read with bypass of the writeback sampled on the coming edge
  // flag 0 is never written so it reads 1 on its own
  function automatic logic read_flag(input sparce_pkg::reg_idx_t idx);
    logic flag;
    flag = zero_flags[idx];
    if (wb_live && (wb.idx == idx)) begin
      flag = wb_zero;
    end
    return flag;
  endfunction

  // both ports follow the flags and the writeback as well as the indices
  always_comb begin
    zero1 = read_flag(rs1);
    zero2 = read_flag(rs2);
  end

endmodule

`default_nettype wire

// File: sparce/sparce_sasa_table.sv
/*
  4-set 4-way skip descriptor table with lru replacement
  lookup is combinational on current contents and registered once, so a
  write sampled on the same edge as a fetch is not seen by that fetch
  duplicate tags in one set are not filtered and the highest way wins
  a write in the same cycle as a hit suppresses the hit's lru update
*/
`default_nettype none

module sparce_sasa_table (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  cfg_valid,
  input  sparce_pkg::sasa_cfg_t cfg,
  input  logic                  fetch_valid,
  input  sparce_pkg::pc_t       fetch_pc,
  output logic                  lookup_valid,
  output sparce_pkg::lookup_t   lookup
);

  // view of the config data word with the preceding pc word address on top
  typedef struct packed {
    sparce_pkg::tag_t       tag;
    sparce_pkg::set_idx_t   set;
    sparce_pkg::reg_idx_t   rs1;
    sparce_pkg::reg_idx_t   rs2;
    sparce_pkg::sasa_cond_t cond;
    sparce_pkg::skip_cnt_t  skip_cnt;
  } sasa_desc_t;

  sparce_pkg::sasa_entry_t entries [sparce_pkg::SASA_SETS][sparce_pkg::SASA_WAYS];

  sasa_desc_t             desc;
  logic                   wr_en;
  sparce_pkg::set_idx_t   pc_set;
  sparce_pkg::tag_t       pc_tag;
  logic                   hit;
  sparce_pkg::way_idx_t   hit_way;
  sparce_pkg::usage_t     hit_usage;
  sparce_pkg::sasa_entry_t hit_entry;
  sparce_pkg::lookup_t    lookup_next;

  assign desc  = sasa_desc_t'(cfg.data);
  assign wr_en = cfg_valid && (cfg.addr == sparce_pkg::SASA_ADDR);

  // byte pc so bits 1:0 are dropped
  assign pc_set = fetch_pc[3:2];
  assign pc_tag = fetch_pc[17:4];

  // tag compare across the ways of the addressed set
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
      if (entries[pc_set][w].valid && (entries[pc_set][w].tag == pc_tag)) begin
        hit     = 1'b1;
        hit_way = sparce_pkg::way_idx_t'(w);
      end
    end
  end

  assign hit_entry = entries[pc_set][hit_way];
  assign hit_usage = hit_entry.usage;

  // a miss carries zero fields
  // pc always travels for the fall-through target
  always_comb begin
    lookup_next     = '0;
    lookup_next.pc  = fetch_pc;
    if (hit) begin
      lookup_next.hit      = 1'b1;
      lookup_next.rs1      = hit_entry.rs1;
      lookup_next.rs2      = hit_entry.rs2;
      lookup_next.cond     = hit_entry.cond;
      lookup_next.skip_cnt = hit_entry.skip_cnt;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int s = 0; s < sparce_pkg::SASA_SETS; s++) begin
        for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
          entries[s][w]       <= '0;
          // way 0 starts oldest so it is the first victim
          entries[s][w].usage <= sparce_pkg::usage_t'(3 - w);
        end
      end
    end else if (wr_en) begin
      for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
        if (entries[desc.set][w].usage == '1) begin
          entries[desc.set][w].valid    <= 1'b1;
          entries[desc.set][w].tag      <= desc.tag;
          entries[desc.set][w].rs1      <= desc.rs1;
          entries[desc.set][w].rs2      <= desc.rs2;
          entries[desc.set][w].cond     <= desc.cond;
          entries[desc.set][w].skip_cnt <= desc.skip_cnt;
        end
        // whole set ages
        // the victim wraps from 3 to 0 and becomes newest
        entries[desc.set][w].usage <= entries[desc.set][w].usage + 2'd1;
      end
    end else if (fetch_valid && hit) begin
      for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
        if (sparce_pkg::way_idx_t'(w) == hit_way) begin
          entries[pc_set][w].usage <= '0;
        end else if (entries[pc_set][w].usage < hit_usage) begin
          // only ways younger than the hit way move up
          entries[pc_set][w].usage <= entries[pc_set][w].usage + 2'd1;
        end
      end
    end
  end

  // stage 1 register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lookup_valid <= 1'b0;
    end else begin
      lookup_valid <= fetch_valid;
    end
  end

  // payload follows each fetch and holds in between
  always_ff @(posedge CLK) begin
    if (fetch_valid) begin
      lookup <= lookup_next;
    end
  end

endmodule

`default_nettype wire

// File: sparce/sparce_cfid.sv
/*
  decision stage, evaluates the skip condition on the stage 1 payload
  register reads go to the sprf combinationally in the same cycle
  result is registered, one cycle after lookup_valid
  skip target wraps silently at the top of the address space
*/
`default_nettype none

module sparce_cfid (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       lookup_valid,
  input  sparce_pkg::lookup_t        lookup,
  output sparce_pkg::reg_idx_t       rs1,
  output sparce_pkg::reg_idx_t       rs2,
  input  logic                       zero1,
  input  logic                       zero2,
  output logic                       result_valid,
  output sparce_pkg::sparce_result_t result
);

  logic                       cond_met;
  sparce_pkg::pc_t            skip_bytes;
  sparce_pkg::sparce_result_t result_next;

  // read indices straight from the looked-up descriptor
  assign rs1 = lookup.rs1;
  assign rs2 = lookup.rs2;

  always_comb begin
    case (lookup.cond)
      sparce_pkg::SASA_COND_AND: cond_met = zero1 && zero2;
      default:                   cond_met = zero1 || zero2;
    endcase
  end

  // skip count plus the preceding instruction itself, in bytes
  assign skip_bytes = (sparce_pkg::pc_t'(lookup.skip_cnt) + 32'd1) << 2;

  always_comb begin
    result_next.skip = lookup.hit && cond_met;
    if (result_next.skip) begin
      result_next.target = lookup.pc + skip_bytes;
    end else begin
      // plain fall-through
      result_next.target = lookup.pc + 32'd4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= lookup_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (lookup_valid) begin
      result <= result_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sparce_unit.sv
/*
  skip prediction unit, table lookup then decide
  result_valid follows fetch_valid by two edges, one fetch per cycle
  no back-pressure anywhere, every strobe is taken
*/
`default_nettype none

module sparce_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       fetch_valid,
  input  sparce_pkg::pc_t            fetch_pc,
  input  logic                       cfg_valid,
  input  sparce_pkg::sasa_cfg_t      cfg,
  input  logic                       wb_valid,
  input  sparce_pkg::wb_t            wb,
  output logic                       result_valid,
  output sparce_pkg::sparce_result_t result
);

  // stage 1 to stage 2
  logic                 lookup_valid;
  sparce_pkg::lookup_t  lookup;

  // sprf read ports
  sparce_pkg::reg_idx_t rs1;
  sparce_pkg::reg_idx_t rs2;
  logic                 zero1;
  logic                 zero2;

  sparce_sasa_table i_sasa_table (
    .CLK          (CLK),
    .nRST         (nRST),
    .cfg_valid    (cfg_valid),
    .cfg          (cfg),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .lookup_valid (lookup_valid),
    .lookup       (lookup)
  );

  sparce_sprf i_sprf (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb_valid (wb_valid),
    .wb       (wb),
    .rs1      (rs1),
    .rs2      (rs2),
    .zero1    (zero1),
    .zero2    (zero2)
  );

  sparce_cfid i_cfid (
    .CLK          (CLK),
    .nRST         (nRST),
    .lookup_valid (lookup_valid),
    .lookup       (lookup),
    .rs1          (rs1),
    .rs2          (rs2),
    .zero1        (zero1),
    .zero2        (zero2),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

// File: tb/sparce_unit_checker.sv
/*
  timing assertions on sparce_unit, attached with bind
  the latency check expects fetch_valid low while nRST is low
  stage 1 signals are taken from the top level's internal wires
*/
`default_nettype none

module sparce_unit_checker (
  input logic                       CLK,
  input logic                       nRST,
  input logic                       fetch_valid,
  input logic                       lookup_valid,
  input sparce_pkg::lookup_t        lookup,
  input logic                       result_valid,
  input sparce_pkg::sparce_result_t result
);

  // one result per fetch, exactly two edges later
  a_latency: assert property (@(posedge CLK) disable iff (!nRST)
    result_valid == $past(fetch_valid, 2))
    else $error("result_valid does not follow fetch_valid by two cycles");

  // nothing comes out of the pipeline in reset
  a_reset_quiet: assert property (@(posedge CLK)
    !nRST |-> !result_valid)
    else $error("result_valid high during reset");

  // a skip needs a table hit in the stage before
  a_skip_needs_hit: assert property (@(posedge CLK) disable iff (!nRST)
    (result_valid && result.skip) |-> $past(lookup_valid && lookup.hit))
    else $error("skip reported without a stage 1 hit");

endmodule

bind sparce_unit sparce_unit_checker i_checker (
  .CLK          (CLK),
  .nRST         (nRST),
  .fetch_valid  (fetch_valid),
  .lookup_valid (lookup_valid),
  .lookup       (lookup),
  .result_valid (result_valid),
  .result       (result)
);

`default_nettype wire

// File: tb/sparce_unit_tb.sv
/*
  directed testbench for sparce_unit
  expected results come from a model of the table with its lru ages and
  of the zero flags, updated with every strobe that is driven
  inputs change on the falling edge, results are sampled there as well
*/
`default_nettype none

module sparce_unit_tb;

  localparam int WAIT_LIMIT = 16;

  logic                       CLK;
  logic                       nRST;
  logic                       fetch_valid;
  sparce_pkg::pc_t            fetch_pc;
  logic                       cfg_valid;
  sparce_pkg::sasa_cfg_t      cfg;
  logic                       wb_valid;
  sparce_pkg::wb_t            wb;
  logic                       result_valid;
  sparce_pkg::sparce_result_t result;

  // reference state
  sparce_pkg::sasa_entry_t model_tab [sparce_pkg::SASA_SETS][sparce_pkg::SASA_WAYS];
  logic [sparce_pkg::NUM_REGS-1:0] model_zero;
  sparce_pkg::sparce_result_t      exp_q [$];
  logic [15:0]                     lfsr;

  sparce_unit i_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .cfg_valid    (cfg_valid),
    .cfg          (cfg),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // byte pc from a tag and a set, bits above 17 left at zero
  function automatic sparce_pkg::pc_t make_pc(input sparce_pkg::tag_t tag,
                                              input sparce_pkg::set_idx_t set);
    return {14'd0, tag, set, 2'b00};
  endfunction

  task automatic model_reset();
    for (int s = 0; s < sparce_pkg::SASA_SETS; s++) begin
      for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
        model_tab[s][w]       = '0;
        model_tab[s][w].usage = sparce_pkg::usage_t'(3 - w);
      end
    end
    model_zero = '1;
  endtask

  // tag match in the pc's set, a hit makes the way newest
  task automatic model_lookup(input sparce_pkg::pc_t pc, output logic hit,
                              output sparce_pkg::sasa_entry_t ent);
    sparce_pkg::set_idx_t set;
    sparce_pkg::usage_t   age;
    int                   way;
    set = pc[3:2];
    way = -1;
    for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
      if (model_tab[set][w].valid && (model_tab[set][w].tag == pc[17:4])) begin
        way = w;
      end
    end
    hit = (way >= 0);
    ent = '0;
    if (hit) begin
      ent = model_tab[set][way];
      age = ent.usage;
      for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
        if (w == way) begin
          model_tab[set][w].usage = 2'd0;
        end else if (model_tab[set][w].usage < age) begin
          model_tab[set][w].usage = model_tab[set][w].usage + 2'd1;
        end
      end
    end
  endtask

  // skip decision on the zero flags as they stand now
  function automatic sparce_pkg::sparce_result_t decide(input sparce_pkg::pc_t pc,
      input logic hit, input sparce_pkg::sasa_entry_t ent);
    sparce_pkg::sparce_result_t r;
    logic                       z1;
    logic                       z2;
    logic                       met;
    z1  = model_zero[ent.rs1];
    z2  = model_zero[ent.rs2];
    met = (ent.cond == sparce_pkg::SASA_COND_AND) ? (z1 && z2) : (z1 || z2);
    r.skip = hit && met;
    // skipped block plus the preceding instruction
    r.target = r.skip ? pc + ({27'd0, ent.skip_cnt} + 32'd1) * 32'd4 : pc + 32'd4;
    return r;
  endfunction

  task automatic check_result(input sparce_pkg::sparce_result_t got,
                              input sparce_pkg::sparce_result_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: result skip %h target %h, expected skip %h target %h",
                          got.skip, got.target, exp.skip, exp.target));
    end
  endtask

  // one falling edge, collect any result, then drop all strobes
  task automatic tick();
    sparce_pkg::sparce_result_t exp;
    @(negedge CLK);
    if (result_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("result_valid came with no fetch outstanding");
      end else begin
        exp = exp_q.pop_front();
        check_result(result, exp);
      end
    end
    fetch_valid = 1'b0;
    cfg_valid   = 1'b0;
    wb_valid    = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == WAIT_LIMIT) begin
        abort_run("timed out waiting for result_valid of an outstanding fetch");
      end
      tick();
      waited++;
    end
  endtask

  task automatic write_reg(input sparce_pkg::reg_idx_t idx, input sparce_pkg::word_t value);
    tick();
    wb_valid = 1'b1;
    wb.idx   = idx;
    wb.value = value;
    // x0 stays zero
    if (idx != '0) begin
      model_zero[idx] = (value == '0);
    end
  endtask

  // the model only takes the write at the table address
  task automatic write_entry(input sparce_pkg::word_t addr, input sparce_pkg::pc_t pc,
                             input sparce_pkg::reg_idx_t rs1, input sparce_pkg::reg_idx_t rs2,
                             input sparce_pkg::sasa_cond_t cond,
                             input sparce_pkg::skip_cnt_t cnt);
    sparce_pkg::set_idx_t set;
    set = pc[3:2];
    tick();
    cfg_valid = 1'b1;
    cfg.addr  = addr;
    cfg.data  = {pc[17:2], rs1, rs2, cond, cnt};
    if (addr == sparce_pkg::SASA_ADDR) begin
      for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
        if (model_tab[set][w].usage == 2'd3) begin
          model_tab[set][w].valid    = 1'b1;
          model_tab[set][w].tag      = pc[17:4];
          model_tab[set][w].rs1      = rs1;
          model_tab[set][w].rs2      = rs2;
          model_tab[set][w].cond     = cond;
          model_tab[set][w].skip_cnt = cnt;
        end
      end
      for (int w = 0; w < sparce_pkg::SASA_WAYS; w++) begin
        model_tab[set][w].usage = model_tab[set][w].usage + 2'd1;
      end
    end
  endtask

  task automatic issue_fetch(input sparce_pkg::pc_t pc);
    logic                    hit;
    sparce_pkg::sasa_entry_t ent;
    model_lookup(pc, hit, ent);
    tick();
    fetch_valid = 1'b1;
    fetch_pc    = pc;
    exp_q.push_back(decide(pc, hit, ent));
  endtask

  task automatic fetch(input sparce_pkg::pc_t pc);
    issue_fetch(pc);
    drain();
  endtask

  // writeback lands in the decision cycle of the fetch
  task automatic fetch_bypass(input sparce_pkg::pc_t pc, input sparce_pkg::reg_idx_t idx,
                              input sparce_pkg::word_t value);
    logic                    hit;
    sparce_pkg::sasa_entry_t ent;
    model_lookup(pc, hit, ent);
    tick();
    fetch_valid = 1'b1;
    fetch_pc    = pc;
    write_reg(idx, value);
    exp_q.push_back(decide(pc, hit, ent));
    drain();
  endtask

  task automatic test_reset_state();
    for (int i = 0; i < 4; i++) begin
      fetch(rand_bits(32) & 32'hFFFF_FFFC);
    end
    write_entry(sparce_pkg::SASA_ADDR + 32'd4, make_pc(14'd9, 2'd1), 5'd0, 5'd0,
                sparce_pkg::SASA_COND_OR, 5'd3);
    fetch(make_pc(14'd9, 2'd1));
  endtask

  task automatic test_or_entry();
    sparce_pkg::pc_t pc;
    pc = make_pc(14'd5, 2'd0);
    write_entry(sparce_pkg::SASA_ADDR, pc, 5'd3, 5'd4, sparce_pkg::SASA_COND_OR, 5'd6);
    write_reg(5'd3, 32'h11);
    write_reg(5'd4, 32'h22);
    fetch(pc);
    write_reg(5'd3, 32'h0);
    fetch(pc);
    write_reg(5'd3, 32'h1);
    write_reg(5'd4, 32'h0);
    fetch(pc);
    fetch(make_pc(14'd6, 2'd0));
  endtask

  task automatic test_and_entry();
    sparce_pkg::pc_t pc;
    pc = make_pc(14'd21, 2'd1);
    write_entry(sparce_pkg::SASA_ADDR, pc, 5'd5, 5'd6, sparce_pkg::SASA_COND_AND, 5'd2);
    write_reg(5'd5, 32'h1);
    write_reg(5'd6, 32'h0);
    fetch(pc);
    write_reg(5'd5, 32'h0);
    fetch(pc);
    // rs1 is x0, so rs2 alone decides
    pc = make_pc(14'd22, 2'd1);
    write_entry(sparce_pkg::SASA_ADDR, pc, 5'd0, 5'd7, sparce_pkg::SASA_COND_AND, 5'd31);
    write_reg(5'd0, 32'hDEAD);
    write_reg(5'd7, 32'h5);
    fetch(pc);
    write_reg(5'd7, 32'h0);
    fetch(pc);
  endtask

  task automatic test_wb_bypass();
    write_reg(5'd3, 32'h7);
    write_reg(5'd4, 32'h9);
    fetch_bypass(make_pc(14'd5, 2'd0), 5'd4, 32'h0);
    fetch_bypass(make_pc(14'd5, 2'd0), 5'd4, 32'h3);
  endtask

  // x0 as rs1 with OR, so every hit skips and every miss does not
  task automatic test_lru_eviction();
    for (int i = 0; i < 5; i++) begin
      write_entry(sparce_pkg::SASA_ADDR, make_pc(sparce_pkg::tag_t'(40 + i), 2'd2), 5'd0,
                  5'd1, sparce_pkg::SASA_COND_OR, sparce_pkg::skip_cnt_t'(i));
    end
    for (int i = 0; i < 5; i++) begin
      fetch(make_pc(sparce_pkg::tag_t'(40 + i), 2'd2));
    end
    for (int i = 0; i < 4; i++) begin
      write_entry(sparce_pkg::SASA_ADDR, make_pc(sparce_pkg::tag_t'(60 + i), 2'd3), 5'd0,
                  5'd1, sparce_pkg::SASA_COND_OR, sparce_pkg::skip_cnt_t'(i + 8));
    end
    // hit on the oldest way moves the victim to the next one
    fetch(make_pc(14'd60, 2'd3));
    write_entry(sparce_pkg::SASA_ADDR, make_pc(14'd64, 2'd3), 5'd0, 5'd1,
                sparce_pkg::SASA_COND_OR, 5'd12);
    for (int i = 0; i < 5; i++) begin
      fetch(make_pc(sparce_pkg::tag_t'(60 + i), 2'd3));
    end
  endtask

  task automatic test_back_to_back();
    sparce_pkg::pc_t pcs [4];
    logic [1:0]      pick;
    for (int r = 1; r < 8; r++) begin
      write_reg(sparce_pkg::reg_idx_t'(r), rand_bits(1) != 0 ? 32'd0 : rand_bits(32));
    end
    for (int i = 0; i < 4; i++) begin
      pcs[i] = make_pc(sparce_pkg::tag_t'(rand_bits(14)), sparce_pkg::set_idx_t'(rand_bits(2)));
      write_entry(sparce_pkg::SASA_ADDR, pcs[i], sparce_pkg::reg_idx_t'(rand_bits(3)),
                  sparce_pkg::reg_idx_t'(rand_bits(3)), sparce_pkg::sasa_cond_t'(rand_bits(1)),
                  sparce_pkg::skip_cnt_t'(rand_bits(5)));
    end
    // a strobe in every cycle, results drained while issuing
    for (int i = 0; i < 24; i++) begin
      if (rand_bits(1) != 0) begin
        pick = 2'(rand_bits(2));
        issue_fetch(pcs[pick]);
      end else begin
        issue_fetch(rand_bits(32) & 32'hFFFF_FFFC);
      end
    end
    drain();
  endtask

  initial begin
    nRST        = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc    = '0;
    cfg_valid   = 1'b0;
    cfg         = '0;
    wb_valid    = 1'b0;
    wb          = '0;
    lfsr        = 16'd34;
    model_reset();
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    test_reset_state();
    test_or_entry();
    test_and_entry();
    test_wb_bypass();
    test_lru_eviction();
    test_back_to_back();
    // quiet cycles, any stray result_valid fails in tick
    repeat (4) tick();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
common/sparce_pkg.sv
sparce/sparce_sprf.sv
sparce/sparce_sasa_table.sv
sparce/sparce_cfid.sv
verilog/sparce_unit.sv
tb/sparce_unit_checker.sv
tb/sparce_unit_tb.sv

// File: Makefile
# Verilator flow for sparce_unit
# every variable below can be overridden on the command line

VERILATOR  ?= verilator
FILELIST   ?= build.f
TOP        ?= sparce_unit_tb
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
